/* cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// data path and address width
`define CPU_DATA_W      32

// register file size
`define CPU_REGS        8
`define CPU_REG_IDX_W   3

// immediate field of the register form, half of a data word
`define CPU_IMM_W       16

// first fetch address after reset
`define CPU_RESET_PC    32'h0000_0000

`endif

/* cpu_pkg.sv */
`include "cpu_config.svh"

package cpu_pkg;

    typedef enum logic [5:0] {
        NOP  = 6'd0,
        ADD  = 6'd1,
        SUB  = 6'd2,
        AND  = 6'd3,
        OR   = 6'd4,
        XOR  = 6'd5,
        SHL  = 6'd6,
        SHR  = 6'd7,
        LDI  = 6'd8,
        LD   = 6'd9,
        ST   = 6'd10,
        BRF  = 6'd11,
        JMP  = 6'd12,
        HALT = 6'd63
    } opcode_e;

    // opcode sits in the low bits of both forms
    typedef struct packed {
        logic [`CPU_IMM_W-1:0]     immediate;
        logic                      high_low;
        logic [`CPU_REG_IDX_W-1:0] rd;
        logic [`CPU_REG_IDX_W-1:0] rb;
        logic [`CPU_REG_IDX_W-1:0] ra;
        opcode_e                   opcode;
    } instr_r_t;

    typedef struct packed {
        logic [`CPU_DATA_W-7:0] target;
        opcode_e                opcode;
    } instr_j_t;

    typedef union packed {
        instr_r_t r_form;
        instr_j_t j_form;
    } instr_u;

    typedef enum logic [1:0] {
        FETCH     = 2'd0,
        EXECUTE   = 2'd1,
        WRITEBACK = 2'd2
    } phase_e;

    typedef struct packed {
        logic [`CPU_DATA_W-1:0] addr;
        logic [`CPU_DATA_W-1:0] wdata;
        logic                   write;
    } mem_req_t;

    typedef struct packed {
        logic [`CPU_DATA_W-1:0] result;
        logic                   flag;
        logic                   take_branch;
        logic [`CPU_DATA_W-1:0] eff_addr;
    } alu_res_t;

    typedef struct packed {
        logic                      en;
        logic [`CPU_REG_IDX_W-1:0] idx;
        logic [`CPU_DATA_W-1:0]    data;
        logic                      flag;
    } reg_wr_t;

endpackage

/* cpu_reg_file.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_reg_file (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic [`CPU_REG_IDX_W-1:0] ra_idx,
    input  logic [`CPU_REG_IDX_W-1:0] rb_idx,
    input  cpu_pkg::reg_wr_t          wr,
    output logic [`CPU_DATA_W-1:0]    rdata_a,
    output logic [`CPU_DATA_W-1:0]    rdata_b,
    output logic                      flag_a
);

    logic [`CPU_DATA_W-1:0] regs [`CPU_REGS];
    logic [`CPU_REGS-1:0]   flags;

    // data word and flag of a register always move together
    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `CPU_REGS; i++)
            begin
                regs[i] <= '0;
            end
            flags <= '0;
        end
        else if (wr.en)
        begin
            regs[wr.idx]  <= wr.data;
            flags[wr.idx] <= wr.flag;
        end
    end

    // reads are asynchronous and return the old value while a write is pending
    assign rdata_a = regs[ra_idx];
    assign rdata_b = regs[rb_idx];
    assign flag_a  = flags[ra_idx];

    // control must present a clean index with every write
    wr_idx_known: assert property (
        @(posedge clock) disable iff (!rst_n)
        wr.en |-> !$isunknown(wr.idx)
    )
    else $error("register write with unknown index %b", wr.idx);

endmodule

/* cpu_alu.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_alu (
    input  cpu_pkg::instr_u         instr,
    input  logic [`CPU_DATA_W-1:0]  op_a,
    input  logic [`CPU_DATA_W-1:0]  op_b,
    input  logic                    flag_a,
    output cpu_pkg::alu_res_t       res
);

    cpu_pkg::instr_r_t      ins;
    logic [`CPU_DATA_W:0]   sum;
    logic [`CPU_DATA_W:0]   diff;
    logic [4:0]             shamt;
    logic [`CPU_DATA_W-1:0] imm_ext;
    logic [`CPU_DATA_W-1:0] result;
    logic                   flag;
    logic                   zero_kind;

    assign ins     = instr.r_form;
    assign imm_ext = {{(`CPU_DATA_W - `CPU_IMM_W){1'b0}}, ins.immediate};

    // one extra bit to catch carry out and borrow
    assign sum   = {1'b0, op_a} + {1'b0, op_b};
    assign diff  = {1'b0, op_a} - {1'b0, op_b};
    assign shamt = op_b[4:0];

    always_comb
    begin
        result    = '0;
        zero_kind = 1'b0;
        flag      = 1'b0;
        case (ins.opcode)
            cpu_pkg::ADD:
            begin
                result = sum[`CPU_DATA_W-1:0];
                flag   = sum[`CPU_DATA_W];
            end
            cpu_pkg::SUB:
            begin
                result = diff[`CPU_DATA_W-1:0];
                flag   = diff[`CPU_DATA_W];
            end
            cpu_pkg::AND:
            begin
                result    = op_a & op_b;
                zero_kind = 1'b1;
            end
            cpu_pkg::OR:
            begin
                result    = op_a | op_b;
                zero_kind = 1'b1;
            end
            cpu_pkg::XOR:
            begin
                result    = op_a ^ op_b;
                zero_kind = 1'b1;
            end
            cpu_pkg::SHL:
            begin
                result    = op_a << shamt;
                zero_kind = 1'b1;
            end
            cpu_pkg::SHR:
            begin
                result    = op_a >> shamt;
                zero_kind = 1'b1;
            end
            cpu_pkg::LDI:
            begin
                // op_b carries rd's current value here
                if (ins.high_low)
                begin
                    result = {ins.immediate, op_b[`CPU_IMM_W-1:0]};
                end
                else
                begin
                    result = {op_b[`CPU_DATA_W-1:`CPU_IMM_W], ins.immediate};
                end
                zero_kind = 1'b1;
            end
            // store data passes through to the bus
            cpu_pkg::ST:
            begin
                result = op_b;
            end
            default:
            begin
                result = '0;
            end
        endcase
        if (zero_kind)
        begin
            flag = (result == '0);
        end
    end

    assign res = '{
        result:      result,
        flag:        flag,
        take_branch: (ins.opcode == cpu_pkg::BRF) && flag_a,
        eff_addr:    op_a + imm_ext
    };

endmodule

/* cpu_control.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_control (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic [`CPU_DATA_W-1:0]    mem_rdata,
    input  cpu_pkg::alu_res_t         alu,
    output cpu_pkg::instr_u           instr,
    output logic [`CPU_REG_IDX_W-1:0] ra_idx,
    output logic [`CPU_REG_IDX_W-1:0] rb_idx,
    output cpu_pkg::reg_wr_t          wr,
    output cpu_pkg::mem_req_t         mem_req,
    output logic                      halted
);

    cpu_pkg::phase_e        phase;
    cpu_pkg::instr_u        ir;
    cpu_pkg::opcode_e       opcode;
    logic [`CPU_DATA_W-1:0] pc;
    logic [`CPU_DATA_W-1:0] pc_next;
    logic [`CPU_DATA_W-1:0] ld_data;
    logic                   is_ld;
    logic                   writes_reg;

    assign instr  = ir;
    assign opcode = ir.r_form.opcode;
    assign is_ld  = (opcode == cpu_pkg::LD);
    assign writes_reg = opcode inside {cpu_pkg::ADD, cpu_pkg::SUB, cpu_pkg::AND, cpu_pkg::OR,
                                       cpu_pkg::XOR, cpu_pkg::SHL, cpu_pkg::SHR, cpu_pkg::LDI,
                                       cpu_pkg::LD};

    // LDI reads its own destination through port b
    assign ra_idx = ir.r_form.ra;
    assign rb_idx = (opcode == cpu_pkg::LDI) ? ir.r_form.rd : ir.r_form.rb;

    always_comb
    begin
        case (opcode)
            cpu_pkg::JMP:  pc_next = {6'd0, ir.j_form.target};
            cpu_pkg::BRF:  pc_next = alu.take_branch ?
                                     {{(`CPU_DATA_W - `CPU_IMM_W){1'b0}}, ir.r_form.immediate} :
                                     pc + 1'b1;
            cpu_pkg::HALT: pc_next = pc;
            default:       pc_next = pc + 1'b1;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            phase  <= cpu_pkg::FETCH;
            pc     <= `CPU_RESET_PC;
            halted <= 1'b0;
        end
        else
        begin
            case (phase)
                cpu_pkg::FETCH:
                begin
                    if (!halted)
                    begin
                        phase <= cpu_pkg::EXECUTE;
                    end
                end
                cpu_pkg::EXECUTE:
                begin
                    phase <= cpu_pkg::WRITEBACK;
                end
                cpu_pkg::WRITEBACK:
                begin
                    phase  <= cpu_pkg::FETCH;
                    pc     <= pc_next;
                    halted <= (opcode == cpu_pkg::HALT);
                end
                default:
                begin
                    phase <= cpu_pkg::FETCH;
                end
            endcase
        end
    end

    always_ff @(posedge clock)
    begin
        if (phase == cpu_pkg::FETCH && !halted)
        begin
            ir <= cpu_pkg::instr_u'(mem_rdata);
        end
        if (phase == cpu_pkg::EXECUTE && is_ld)
        begin
            ld_data <= mem_rdata;
        end
    end

    assign wr = '{
        en:   (phase == cpu_pkg::WRITEBACK) && writes_reg,
        idx:  ir.r_form.rd,
        data: is_ld ? ld_data : alu.result,
        flag: is_ld ? (ld_data == '0) : alu.flag
    };

    // data address only while executing a load or store
    assign mem_req = '{
        addr:  (phase == cpu_pkg::EXECUTE && (is_ld || opcode == cpu_pkg::ST)) ?
               alu.eff_addr : pc,
        wdata: alu.result,
        write: (phase == cpu_pkg::EXECUTE) && (opcode == cpu_pkg::ST)
    };

    // a store drives the bus in the one cycle that follows its fetch
    st_one_cycle: assert property (
        @(posedge clock) disable iff (!rst_n)
        mem_req.write |-> ($past(phase) == cpu_pkg::FETCH && !halted)
                          ##1 !mem_req.write
    )
    else $error("bus write outside the execute cycle of a store");

    phase_legal: assert property (
        @(posedge clock) disable iff (!rst_n)
        !$isunknown(phase) && phase != 2'b11
    )
    else $error("phase register holds %b", phase);

    halt_sticky: assert property (
        @(posedge clock) disable iff (!rst_n)
        halted |=> halted && phase == cpu_pkg::FETCH
    )
    else $error("machine left the halted state without reset");

endmodule

/* cpu_top.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_top (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic [`CPU_DATA_W-1:0] mem_rdata,
    output cpu_pkg::mem_req_t      mem_req,
    output logic                   halted
);

    cpu_pkg::instr_u           instr;
    cpu_pkg::reg_wr_t          wr;
    cpu_pkg::alu_res_t         alu_res;
    logic [`CPU_REG_IDX_W-1:0] ra_idx;
    logic [`CPU_REG_IDX_W-1:0] rb_idx;
    logic [`CPU_DATA_W-1:0]    rdata_a;
    logic [`CPU_DATA_W-1:0]    rdata_b;
    logic                      flag_a;

    // sequencing, pc and bus request
    cpu_control u_control (
        .clock     (clock),
        .rst_n     (rst_n),
        .mem_rdata (mem_rdata),
        .alu       (alu_res),
        .instr     (instr),
        .ra_idx    (ra_idx),
        .rb_idx    (rb_idx),
        .wr        (wr),
        .mem_req   (mem_req),
        .halted    (halted)
    );

    cpu_reg_file u_reg_file (
        .clock   (clock),
        .rst_n   (rst_n),
        .ra_idx  (ra_idx),
        .rb_idx  (rb_idx),
        .wr      (wr),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b),
        .flag_a  (flag_a)
    );

    // purely combinational, works from the latched instruction
    cpu_alu u_alu (
        .instr  (instr),
        .op_a   (rdata_a),
        .op_b   (rdata_b),
        .flag_a (flag_a),
        .res    (alu_res)
    );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock,
    output logic rst_n
);

    initial
    begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // power-on reset held for five cycles
    initial
    begin
        rst_n = 1'b0;
        repeat (5) @(posedge clock);
        #2 rst_n = 1'b1;
    end

endmodule

/* cpu_tb.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_tb;

    // summed length of all test programs, three cycles each, plus reset time
    localparam int PROG_LEN_TOTAL = 96;
    localparam int CYCLE_LIMIT    = 3 * PROG_LEN_TOTAL + 150;

    logic                   clock;
    logic                   por_n;
    logic                   test_rst_n;
    logic                   rst_n;
    logic [`CPU_DATA_W-1:0] mem_rdata;
    cpu_pkg::mem_req_t      mem_req;
    logic                   halted;
    logic [31:0]            mem [256];
    logic                   write_seen;
    int                     pc_w;
    int                     errors;
    int                     cycles;
    integer                 seed;

    tb_clock_gen u_clock_gen (
        .clock (clock),
        .rst_n (por_n)
    );

    assign rst_n = por_n & test_rst_n;

    cpu_top DUT (
        .clock     (clock),
        .rst_n     (rst_n),
        .mem_rdata (mem_rdata),
        .mem_req   (mem_req),
        .halted    (halted)
    );

    // memory answers in the same cycle
    assign mem_rdata = mem[mem_req.addr[7:0]];

    always @(posedge clock)
    begin
        if (mem_req.write === 1'b1)
        begin
            mem[mem_req.addr[7:0]] <= mem_req.wdata;
            write_seen <= 1'b1;
        end
    end

    always @(posedge clock)
    begin
        cycles++;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("run timed out after %0d cycles", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic logic [31:0] enc_r(input logic [5:0] op, input logic [2:0] ra,
                                          input logic [2:0] rb, input logic [2:0] rd,
                                          input logic hl, input logic [15:0] imm);
        return {imm, hl, rd, rb, ra, op};
    endfunction

    function automatic logic [31:0] enc_j(input logic [5:0] op, input logic [25:0] target);
        return {target, op};
    endfunction

    task automatic tick();
        @(posedge clock);
        #2;
    endtask

    task automatic start_program();
        for (int i = 0; i < 256; i++)
        begin
            mem[i] = 32'hC0DE_0000 | (i * 32'h0101);
        end
        pc_w = 0;
    endtask

    task automatic emit(input logic [31:0] word);
        mem[pc_w] = word;
        pc_w++;
    endtask

    task automatic ldi32(input logic [2:0] rd, input logic [31:0] value);
        emit(enc_r(cpu_pkg::LDI, 3'd0, 3'd0, rd, 1'b0, value[15:0]));
        emit(enc_r(cpu_pkg::LDI, 3'd0, 3'd0, rd, 1'b1, value[31:16]));
    endtask

    task automatic store(input logic [2:0] ra, input logic [2:0] rb, input logic [15:0] imm);
        emit(enc_r(cpu_pkg::ST, ra, rb, 3'd0, 1'b0, imm));
    endtask

    task automatic pulse_reset();
        tick();
        test_rst_n = 1'b0;
        repeat (5) tick();
        write_seen = 1'b0;
        test_rst_n = 1'b1;
    endtask

    task automatic run_program();
        emit(enc_r(cpu_pkg::HALT, 3'd0, 3'd0, 3'd0, 1'b0, 16'd0));
        pulse_reset();
        while (halted !== 1'b1)
        begin
            tick();
        end
    endtask

    task automatic check_word(input logic [7:0] addr, input logic [31:0] exp);
        assert (mem[addr] === exp)
        else
        begin
            $display("ERR mem[%02h] exp %08h got %08h", addr, exp, mem[addr]);
            errors++;
        end
    endtask

    task automatic report(input string name, input int err_before);
        $display("%-12s %s", name, (errors == err_before) ? "passed" : "FAILED");
    endtask

    task automatic test_reset_halt();
        int e;
        e = errors;
        start_program();
        run_program();
        assert (write_seen === 1'b0)
        else
        begin
            $display("bus write seen while only HALT was executed");
            errors++;
        end
        start_program();
        emit(enc_r(cpu_pkg::LDI, 3'd0, 3'd0, 3'd1, 1'b0, 16'h00AB));
        store(3'd0, 3'd1, 16'h0080);
        emit(enc_r(cpu_pkg::HALT, 3'd0, 3'd0, 3'd0, 1'b0, 16'd0));
        pulse_reset();
        // first instruction occupies exactly three cycles
        repeat (3) tick();
        assert (mem_req.addr === 32'd1)
        else
        begin
            $display("ERR mem_req.addr exp %08h got %08h", 32'd1, mem_req.addr);
            errors++;
        end
        while (halted !== 1'b1)
        begin
            tick();
        end
        check_word(8'h80, 32'h0000_00AB);
        report("reset_halt", e);
    endtask

    task automatic test_ldi_store();
        int e;
        e = errors;
        start_program();
        ldi32(3'd1, 32'hDEAD_BEEF);
        ldi32(3'd2, 32'h0000_0080);
        store(3'd2, 3'd1, 16'h0004);
        run_program();
        check_word(8'h84, 32'hDEAD_BEEF);
        check_word(8'h85, 32'hC0DE_0000 | (32'h85 * 32'h0101));
        report("ldi_store", e);
    endtask

    task automatic test_alu_ops();
        int e;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] exp [7];
        logic [5:0]  ops [7];
        e = errors;
        a = $random(seed);
        b = $random(seed);
        ops = '{cpu_pkg::ADD, cpu_pkg::SUB, cpu_pkg::AND, cpu_pkg::OR,
                cpu_pkg::XOR, cpu_pkg::SHL, cpu_pkg::SHR};
        exp = '{a + b, a - b, a & b, a | b, a ^ b, a << b[4:0], a >> b[4:0]};
        start_program();
        ldi32(3'd1, a);
        ldi32(3'd2, b);
        for (int i = 0; i < 7; i++)
        begin
            emit(enc_r(ops[i], 3'd1, 3'd2, 3'd3, 1'b0, 16'd0));
            store(3'd0, 3'd3, 16'h0090 + i);
        end
        run_program();
        for (int i = 0; i < 7; i++)
        begin
            check_word(8'h90 + i, exp[i]);
        end
        report("alu_ops", e);
    endtask

    // one flag-setting instruction into r3, then a branch that skips the marker store
    task automatic branch_case(input logic [31:0] op_word, input int k);
        emit(op_word);
        emit(enc_r(cpu_pkg::BRF, 3'd3, 3'd0, 3'd0, 1'b0, 16'(pc_w + 2)));
        store(3'd0, 3'd5, 16'h00A0 + k);
    endtask

    task automatic test_flags();
        int e;
        logic taken [8];
        e = errors;
        taken = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
        start_program();
        mem[8'hB0] = 32'h0;
        mem[8'hB1] = 32'h7;
        ldi32(3'd5, 32'h0000_5A5A);
        ldi32(3'd1, 32'hFFFF_FFFF);
        ldi32(3'd2, 32'h0000_0001);
        ldi32(3'd6, 32'h0000_0002);
        branch_case(enc_r(cpu_pkg::ADD, 3'd1, 3'd2, 3'd3, 1'b0, 16'd0), 0);
        branch_case(enc_r(cpu_pkg::ADD, 3'd2, 3'd2, 3'd3, 1'b0, 16'd0), 1);
        branch_case(enc_r(cpu_pkg::SUB, 3'd2, 3'd6, 3'd3, 1'b0, 16'd0), 2);
        branch_case(enc_r(cpu_pkg::SUB, 3'd6, 3'd2, 3'd3, 1'b0, 16'd0), 3);
        branch_case(enc_r(cpu_pkg::XOR, 3'd1, 3'd1, 3'd3, 1'b0, 16'd0), 4);
        branch_case(enc_r(cpu_pkg::XOR, 3'd1, 3'd2, 3'd3, 1'b0, 16'd0), 5);
        branch_case(enc_r(cpu_pkg::LD, 3'd0, 3'd0, 3'd3, 1'b0, 16'h00B0), 6);
        branch_case(enc_r(cpu_pkg::LD, 3'd0, 3'd0, 3'd3, 1'b0, 16'h00B1), 7);
        run_program();
        for (int k = 0; k < 8; k++)
        begin
            check_word(8'hA0 + k, taken[k] ? (32'hC0DE_0000 | ((32'hA0 + k) * 32'h0101))
                                            : 32'h0000_5A5A);
        end
        report("flags", e);
    endtask

    task automatic test_load_jump();
        int e;
        e = errors;
        start_program();
        mem[8'hC0] = 32'h1357_2468;
        emit(enc_r(cpu_pkg::LD, 3'd0, 3'd0, 3'd1, 1'b0, 16'h00C0));
        store(3'd0, 3'd1, 16'h00C1);
        emit(enc_j(cpu_pkg::JMP, 26'(pc_w + 2)));
        store(3'd0, 3'd1, 16'h00C2);
        run_program();
        check_word(8'hC1, 32'h1357_2468);
        check_word(8'hC2, 32'hC0DE_0000 | (32'hC2 * 32'h0101));
        report("load_jump", e);
    endtask

    task automatic test_reg_isolation();
        int e;
        e = errors;
        start_program();
        for (int i = 0; i < 8; i++)
        begin
            ldi32(3'(i), 32'h1111_1111 * i);
        end
        ldi32(3'd7, 32'h7E7E_7E7E);
        ldi32(3'd0, 32'h0000_0010);
        // r0 is the base, so offsets are taken relative to 0x10
        for (int i = 0; i < 8; i++)
        begin
            store(3'd0, 3'(i), 16'h00C0 + i);
        end
        run_program();
        check_word(8'hD0, 32'h0000_0010);
        for (int i = 1; i < 7; i++)
        begin
            check_word(8'hD0 + i, 32'h1111_1111 * i);
        end
        check_word(8'hD7, 32'h7E7E_7E7E);
        report("reg_isolate", e);
    endtask

    initial
    begin
        test_rst_n = 1'b1;
        write_seen = 1'b0;
        errors     = 0;
        cycles     = 0;
        seed       = 6781;
        pc_w       = 0;
        start_program();
        mem[0] = enc_r(cpu_pkg::HALT, 3'd0, 3'd0, 3'd0, 1'b0, 16'd0);
        wait (por_n === 1'b1);
        test_reset_halt();
        test_ldi_store();
        test_alu_ops();
        test_flags();
        test_load_jump();
        test_reg_isolation();
        $display("checks failed: %0d, cycles used: %0d", errors, cycles);
        if (errors == 0)
        begin
            $display("All tests passed!");
        end
        else
        begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+.
cpu_pkg.sv
cpu_reg_file.sv
cpu_alu.sv
cpu_control.sv
cpu_top.sv
tb_clock_gen.sv
cpu_tb.sv
